//--- hw/read_dp_config.svh
`ifndef READ_DP_CONFIG_SVH
`define READ_DP_CONFIG_SVH

// ************************************************************
// Memory side geometry
// ************************************************************

// DQ pins on the memory interface
`define RDP_MEM_DQ_WIDTH 8
// Read DQS groups and the DQ pins that each one strobes
`define RDP_READ_DQS_WIDTH 2
`define RDP_DQ_GROUP_WIDTH 4

// ************************************************************
// AFI side geometry
// ************************************************************

// Half rate core with two AFI phases per clock
`define RDP_AFI_RATE_RATIO 2
// Four DDR time slots land in one AFI clock
`define RDP_NUM_TIMESLOTS 4
`define RDP_AFI_DATA_WIDTH 32

// Extra alignment of the read enable in AFI cycles, never below one
`define RDP_EXTRA_VFIFO_SHIFT 2
// Latency shifter length and the tap select that indexes it
`define RDP_MAX_READ_LATENCY 32
`define RDP_LATENCY_COUNT_WIDTH 5

// Memory read latency in memory clocks
`define RDP_MEM_T_RL 11
// OCT window edges in AFI cycles, derived from the read latency
`define RDP_OCT_ON_DELAY ((`RDP_MEM_T_RL > 4) ? ((`RDP_MEM_T_RL - 4) / 2) : 0)
`define RDP_OCT_OFF_DELAY ((`RDP_MEM_T_RL + 6) / 2)

`endif

//--- hw/read_dp_pkg.sv
`default_nettype none

`include "read_dp_config.svh"

// Bus types shared between the read datapath blocks and the testbench
package read_dp_pkg;

	// ************************************************************
	// Per-cycle control levels
	// ************************************************************

	// One bit per AFI phase, used for read enables and read valid
	typedef logic [`RDP_AFI_RATE_RATIO-1:0] afi_phase_t;

	// One bit per read DQS group, used for the OCT-off levels
	typedef logic [`RDP_READ_DQS_WIDTH-1:0] dqs_group_t;

	// Tap select that the sequencer writes after latency calibration
	typedef logic [`RDP_LATENCY_COUNT_WIDTH-1:0] lat_count_t;

	// ************************************************************
	// Read data
	// ************************************************************

	// A full AFI clock worth of read data
	// The same width carries the DDIO word, the AFI word and the sequencer word
	typedef logic [`RDP_AFI_DATA_WIDTH-1:0] rdata_word_t;

endpackage

`default_nettype wire

//--- hw/rdata_en_delay.sv
`timescale 1ns/1ps
`default_nettype none

`include "read_dp_config.svh"

// Input side alignment of the controller read enables
// Each AFI phase goes through its own shift register of fixed length
module rdata_en_delay
	import read_dp_pkg::*;
(
	input  wire        pll_afi_clk,
	input  wire        reset_n_afi_clk,
	// Read enable strobes straight from the controller
	input  afi_phase_t afi_rdata_en_i,
	// The same strobes after the extra shift
	output afi_phase_t rdata_en_dly_o
);

	localparam int SHIFT = `RDP_EXTRA_VFIFO_SHIFT;

	genvar phase;

	generate
		for (phase = 0; phase < `RDP_AFI_RATE_RATIO; phase++)
		begin : g_phase
			// Stage 0 takes the strobe and the last stage drives the output
			logic [SHIFT-1:0] shift_q;
			// New strobe appended below the stored stages
			logic [SHIFT:0]   shift_next;

			assign shift_next = {shift_q, afi_rdata_en_i[phase]};

			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
			begin
				if (!reset_n_afi_clk)
				begin
					shift_q <= '0;
				end
				else
				begin
					// Every stage moves up by one each AFI cycle
					shift_q <= shift_next[SHIFT-1:0];
				end
			end

			// A strobe sampled at edge E shows here after edge E+SHIFT-1
			// The top bit of shift_next is the last stored stage
			assign rdata_en_dly_o[phase] = shift_next[SHIFT];
		end
	endgenerate

endmodule

`default_nettype wire

//--- hw/read_latency_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "read_dp_config.svh"

// Read valid generation from the calibrated read latency
// The delayed enable runs through a long shift register and the
// sequencer picks the tap that lines up with the returned data
module read_latency_select
	import read_dp_pkg::*;
(
	input  wire        pll_afi_clk,
	input  wire        reset_n_afi_clk,
	// Delayed read enable of AFI phase 0
	input  wire        rdata_en_i,
	// Tap position found by the sequencer during calibration
	input  lat_count_t seq_read_latency_counter_i,
	// Registered read valid towards the controller
	output afi_phase_t afi_rdata_valid_o
);

	localparam int DEPTH = `RDP_MAX_READ_LATENCY;

	// ************************************************************
	// Latency shifter
	// ************************************************************

	// Bit k holds the enable that entered k+1 edges ago
	logic [DEPTH-1:0] latency_shifter;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter <= '0;
		end
		else
		begin
			// A zero goes in on idle cycles so the shifter always holds a
			// faithful picture of the last DEPTH enable samples
			latency_shifter <= {latency_shifter[DEPTH-2:0], rdata_en_i};
		end
	end

	// ************************************************************
	// Tap selection
	// ************************************************************

	// Selected tap after one register stage
	logic read_valid_tap;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_valid_tap <= 1'b0;
		end
		else
		begin
			// The select only changes while no enable is in flight
			// so a switch of tap never cuts a valid burst short
			read_valid_tap <= latency_shifter[seq_read_latency_counter_i];
		end
	end

	// ************************************************************
	// AFI read valid
	// ************************************************************

	// Both phases come from the phase 0 tap
	// Phase 1 of the enable never reaches this block
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			afi_rdata_valid_o <= '0;
		end
		else
		begin
			afi_rdata_valid_o <= {`RDP_AFI_RATE_RATIO{read_valid_tap}};
		end
	end

	// End to end the valid rises after edge E+SHIFT+L+2 for an
	// enable sampled at edge E and stays high as long as the enable was

endmodule

`default_nettype wire

//--- hw/oct_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "read_dp_config.svh"

// On-die termination control around reads
// Termination is forced off except in a window that brackets the
// returning read burst on the DQ pins
module oct_control
	import read_dp_pkg::*;
(
	input  wire        pll_afi_clk,
	input  wire        reset_n_afi_clk,
	// Undelayed full read enable of AFI phase 0
	input  wire        rdata_en_full_i,
	// High forces OCT off for that DQS group
	output dqs_group_t force_oct_off_o
);

	localparam int ON_DLY  = `RDP_OCT_ON_DELAY;
	localparam int OFF_DLY = `RDP_OCT_OFF_DELAY;

	// ************************************************************
	// Enable history
	// ************************************************************

	// Bit k holds the enable sampled k+1 edges back
	logic [OFF_DLY-1:0] rdata_en_hist;
	// Current enable below the history so bit k is k edges back
	logic [OFF_DLY:0]   rdata_en_window;

	assign rdata_en_window = {rdata_en_hist, rdata_en_full_i};

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_hist   <= '0;
			// Termination stays as is during reset
			force_oct_off_o <= '0;
		end
		else
		begin
			rdata_en_hist <= rdata_en_window[OFF_DLY-1:0];
			// Any read from ON_DLY to OFF_DLY edges back opens the window
			// and every group follows the same window
			force_oct_off_o <= {`RDP_READ_DQS_WIDTH{~(|rdata_en_window[OFF_DLY:ON_DLY])}};
		end
	end

endmodule

`default_nettype wire

//--- hw/read_data_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "read_dp_config.svh"

// Read data reordering between the DDIO, the AFI and the sequencer
// The DDIO word is ordered by DQS group with time slots inside a group
// The AFI word is ordered by time slot with groups inside a slot
module read_data_map
	import read_dp_pkg::*;
(
	// Group-major read word from the I/O block
	input  rdata_word_t ddio_phy_dq_i,
	// Slot-major read word towards the controller
	output rdata_word_t afi_rdata_o,
	// Group-major copy rebuilt from the AFI word for the sequencer
	output rdata_word_t phy_mux_read_fifo_q_o
);

	localparam int LANE  = `RDP_DQ_GROUP_WIDTH;
	// One time slot across all groups
	localparam int SLOT  = `RDP_MEM_DQ_WIDTH;
	// One group across all time slots
	localparam int GROUP = `RDP_AFI_DATA_WIDTH / `RDP_READ_DQS_WIDTH;

	genvar grp;
	genvar slot;

	generate
		for (grp = 0; grp < `RDP_READ_DQS_WIDTH; grp++)
		begin : g_group
			for (slot = 0; slot < `RDP_NUM_TIMESLOTS; slot++)
			begin : g_slot
				// DQ lane of this group in this time slot
				logic [LANE-1:0] ddio_lane;
				// The same lane picked back out of the AFI word
				logic [LANE-1:0] afi_lane;

				assign ddio_lane = ddio_phy_dq_i[grp*GROUP + slot*LANE +: LANE];

				// Slot-major placement on the AFI bus
				assign afi_rdata_o[slot*SLOT + grp*LANE +: LANE] = ddio_lane;

				// Sequencer copy is taken from the AFI word
				assign afi_lane = afi_rdata_o[slot*SLOT + grp*LANE +: LANE];

				// Back to group-major order for per-group calibration
				assign phy_mux_read_fifo_q_o[grp*GROUP + slot*LANE +: LANE] = afi_lane;
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- hw/read_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "read_dp_config.svh"

// AFI clock half of the DDR3 PHY read datapath
// The read FIFOs sit in the I/O block so the core only aligns the
// enables, builds read valid, reorders the data and drives OCT
module read_datapath
	import read_dp_pkg::*;
(
	input  wire         pll_afi_clk,
	input  wire         reset_n_afi_clk,
	// Read enables from the controller
	input  afi_phase_t  afi_rdata_en_i,
	input  afi_phase_t  afi_rdata_en_full_i,
	// Calibrated read latency from the sequencer
	input  lat_count_t  seq_read_latency_counter_i,
	// Read data from the DDIO registers
	input  rdata_word_t ddio_phy_dq_i,
	// Read data and valid towards the controller
	output rdata_word_t afi_rdata_o,
	output afi_phase_t  afi_rdata_valid_o,
	// Read data towards the sequencer
	output rdata_word_t phy_mux_read_fifo_q_o,
	// OCT override per DQS group
	output dqs_group_t  force_oct_off_o
);

	// ************************************************************
	// Read valid path
	// ************************************************************

	// Read enables after the extra alignment shift
	afi_phase_t rdata_en_dly;

	rdata_en_delay u_rdata_en_delay
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_i  (afi_rdata_en_i),
		.rdata_en_dly_o  (rdata_en_dly)
	);

	// Only phase 0 feeds the latency shifter
	read_latency_select u_read_latency_select
	(
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.rdata_en_i                 (rdata_en_dly[0]),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.afi_rdata_valid_o          (afi_rdata_valid_o)
	);

	// ************************************************************
	// Termination control
	// ************************************************************

	// OCT works from the full enable without the extra shift
	oct_control u_oct_control
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (afi_rdata_en_full_i[0]),
		.force_oct_off_o (force_oct_off_o)
	);

	// ************************************************************
	// Read data path
	// ************************************************************

	// Purely combinational reordering with no added latency
	read_data_map u_read_data_map
	(
		.ddio_phy_dq_i         (ddio_phy_dq_i),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o)
	);

endmodule

`default_nettype wire

//--- test/read_datapath_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "read_dp_config.svh"

// Concurrent assertions on the read datapath ports
// Bound into the top level so they watch every instance
module read_datapath_checker
(
	input wire                           pll_afi_clk,
	input wire                           reset_n_afi_clk,
	input wire [`RDP_AFI_RATE_RATIO-1:0] afi_rdata_valid_i,
	input wire [`RDP_READ_DQS_WIDTH-1:0] force_oct_off_i,
	input wire [`RDP_AFI_DATA_WIDTH-1:0] ddio_phy_dq_i,
	input wire [`RDP_AFI_DATA_WIDTH-1:0] phy_mux_read_fifo_q_i
);

	// A valid needs at least the enable shift plus two edges to appear
	localparam int QUIET_CYCLES = `RDP_EXTRA_VFIFO_SHIFT + 2;

	// Number of assertion failures so far
	int error_count = 0;

	// Both valid phases come from the single phase 0 tap
	valid_phases_equal: assert property (@(posedge pll_afi_clk)
		disable iff (!reset_n_afi_clk)
		(afi_rdata_valid_i == '0) || (afi_rdata_valid_i == '1))
	else
	begin
		$error("afi_rdata_valid phases differ");
		error_count++;
	end

	// Every DQS group follows the same OCT window
	oct_groups_equal: assert property (@(posedge pll_afi_clk)
		disable iff (!reset_n_afi_clk)
		(force_oct_off_i == '0) || (force_oct_off_i == '1))
	else
	begin
		$error("force_oct_off groups differ");
		error_count++;
	end

	// The two reorderings cancel out
	seq_copy_matches_ddio: assert property (@(posedge pll_afi_clk)
		phy_mux_read_fifo_q_i == ddio_phy_dq_i)
	else
	begin
		$error("phy_mux_read_fifo_q differs from ddio_phy_dq");
		error_count++;
	end

	// No valid can leave the pipeline right after reset
	valid_quiet_after_reset: assert property (@(posedge pll_afi_clk)
		$rose(reset_n_afi_clk) |-> (afi_rdata_valid_i == '0) [*QUIET_CYCLES])
	else
	begin
		$error("afi_rdata_valid rose too soon after reset");
		error_count++;
	end

endmodule

`default_nettype wire

//--- test/read_datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "read_dp_config.svh"

// Testbench for the AFI clock half of the read datapath
// A reference model predicts every output from the sampled inputs
module read_datapath_tb
	import read_dp_pkg::*;
();

	localparam int SHIFT = `RDP_EXTRA_VFIFO_SHIFT;
	// Worst case lengths of the five tests in AFI cycles
	localparam int RUN_CYCLES = 8 + 6 * 90 + 290 + 100 + 110;
	// Watchdog limit with half again as margin
	localparam int TIMEOUT_NS = RUN_CYCLES * 20 * 3 / 2;

	logic        pll_afi_clk;
	logic        reset_n_afi_clk;
	afi_phase_t  afi_rdata_en;
	afi_phase_t  afi_rdata_en_full;
	lat_count_t  seq_read_latency_counter;
	rdata_word_t ddio_phy_dq;
	rdata_word_t afi_rdata;
	rdata_word_t phy_mux_read_fifo_q;
	afi_phase_t  afi_rdata_valid;
	dqs_group_t  force_oct_off;

	// Phase 0 enables as the DUT sampled them
	// Bit k is k edges back
	logic [63:0] en_hist;
	logic [63:0] full_hist;

	string test_name;
	int    test_errors;
	int    tests_passed;
	int    tests_failed;
	bit    compare_on;

	read_datapath u_read_datapath
	(
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en),
		.afi_rdata_en_full_i        (afi_rdata_en_full),
		.seq_read_latency_counter_i (seq_read_latency_counter),
		.ddio_phy_dq_i              (ddio_phy_dq),
		.afi_rdata_o                (afi_rdata),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q),
		.force_oct_off_o            (force_oct_off)
	);

	// Port assertions ride along inside the DUT
	bind read_datapath read_datapath_checker u_read_datapath_checker
	(
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.afi_rdata_valid_i     (afi_rdata_valid_o),
		.force_oct_off_i       (force_oct_off_o),
		.ddio_phy_dq_i         (ddio_phy_dq_i),
		.phy_mux_read_fifo_q_i (phy_mux_read_fifo_q_o)
	);

	initial pll_afi_clk = 1'b0;
	always #10 pll_afi_clk = ~pll_afi_clk;

	// ************************************************************
	// Reference model
	// ************************************************************

	// Record what the DUT samples at each edge
	// The history is cleared while in reset
	always @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist   <= '0;
			full_hist <= '0;
		end
		else
		begin
			// Only phase 0 of either enable matters to the datapath
			en_hist   <= {en_hist[62:0], afi_rdata_en[0]};
			full_hist <= {full_hist[62:0], afi_rdata_en_full[0]};
		end
	end

	function automatic void ref_step(
		input  rdata_word_t ddio,
		input  lat_count_t  lat,
		input  logic [63:0] en_past,
		input  logic [63:0] full_past,
		output afi_phase_t  exp_valid,
		output dqs_group_t  exp_oct,
		output rdata_word_t exp_rdata,
		output rdata_word_t exp_seq
	);
		logic in_window;
		int   k;
		int   g;
		int   t;
		// Valid shows on both phases S+L+2 edges after the enable
		exp_valid = {`RDP_AFI_RATE_RATIO{en_past[SHIFT + lat + 2]}};
		// OCT is off unless a read lies 3 to 8 edges back
		in_window = 1'b0;
		for (k = 3; k <= 8; k++)
			in_window = in_window | full_past[k];
		exp_oct = in_window ? '0 : '1;
		// Group-major DDIO lanes move to slot-major AFI lanes and back
		for (g = 0; g < 2; g++)
		begin
			for (t = 0; t < 4; t++)
			begin
				exp_rdata[t*8 + g*4 +: 4] = ddio[g*16 + t*4 +: 4];
				exp_seq[g*16 + t*4 +: 4]  = exp_rdata[t*8 + g*4 +: 4];
			end
		end
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		$display("ERROR %s %s expected %0h actual %0h at %0t", test_name, what, exp, act,
			$time);
		test_errors++;
	endtask

	// Outputs are settled half a cycle after the edge
	always @(negedge pll_afi_clk)
	begin : compare_outputs
		afi_phase_t  exp_valid;
		dqs_group_t  exp_oct;
		rdata_word_t exp_rdata;
		rdata_word_t exp_seq;
		if (compare_on)
		begin
			ref_step(ddio_phy_dq, seq_read_latency_counter, en_hist, full_hist,
				exp_valid, exp_oct, exp_rdata, exp_seq);
			if (afi_rdata_valid !== exp_valid)
				report_mismatch("afi_rdata_valid", exp_valid, afi_rdata_valid);
			if (force_oct_off !== exp_oct)
				report_mismatch("force_oct_off", exp_oct, force_oct_off);
			if (afi_rdata !== exp_rdata)
				report_mismatch("afi_rdata", exp_rdata, afi_rdata);
			if (phy_mux_read_fifo_q !== exp_seq)
				report_mismatch("phy_mux_read_fifo_q", exp_seq, phy_mux_read_fifo_q);
		end
	end

	// ************************************************************
	// Test sequencing
	// ************************************************************

	// Inputs change 2 ns after the rising edge
	task automatic next_drive();
		@(posedge pll_afi_clk);
		#2;
	endtask

	task automatic open_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic close_test();
		if (test_errors == 0)
		begin
			tests_passed++;
			$display("Test %s ok", test_name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s had %0d errors", test_name, test_errors);
		end
	endtask

	initial
	begin : run_tests
		lat_count_t lat;
		int         k;
		int         hit_count;
		int         first_hit;
		int         en_count;
		int         assert_errors;
		void'($urandom(32'h172f));
		reset_n_afi_clk          = 1'b0;
		afi_rdata_en             = '0;
		afi_rdata_en_full        = '0;
		seq_read_latency_counter = '0;
		ddio_phy_dq              = '0;
		compare_on               = 1'b0;
		tests_passed             = 0;
		tests_failed             = 0;
		test_errors              = 0;

		// Outputs stay low through reset and the first cycle after it
		open_test("reset_state");
		repeat (3)
		begin
			@(negedge pll_afi_clk);
			if (afi_rdata_valid !== 2'b00)
				report_mismatch("valid in reset", 0, afi_rdata_valid);
			if (force_oct_off !== 2'b00)
				report_mismatch("oct in reset", 0, force_oct_off);
		end
		next_drive();
		reset_n_afi_clk = 1'b1;
		@(negedge pll_afi_clk);
		if (afi_rdata_valid !== 2'b00)
			report_mismatch("valid cycle 1", 0, afi_rdata_valid);
		if (force_oct_off !== 2'b00)
			report_mismatch("oct cycle 1", 0, force_oct_off);
		@(negedge pll_afi_clk);
		if (afi_rdata_valid !== 2'b00)
			report_mismatch("valid cycle 2", 0, afi_rdata_valid);
		if (force_oct_off !== 2'b11)
			report_mismatch("oct cycle 2", 3, force_oct_off);
		next_drive();
		compare_on = 1'b1;
		close_test();

		// One pulse per latency gives exactly one valid cycle L+4 edges on
		open_test("single_read_latency");
		repeat (6)
		begin
			// Nothing may be in flight when the tap moves
			repeat (40) next_drive();
			lat = lat_count_t'($urandom % `RDP_MAX_READ_LATENCY);
			seq_read_latency_counter = lat;
			repeat (2) next_drive();
			afi_rdata_en = 2'b01;
			next_drive();
			afi_rdata_en = 2'b00;
			hit_count = 0;
			first_hit = 0;
			for (k = 0; k <= lat + 12; k++)
			begin
				@(negedge pll_afi_clk);
				if (afi_rdata_valid == 2'b11)
				begin
					if (hit_count == 0)
						first_hit = k;
					hit_count++;
				end
			end
			if (hit_count != 1)
				report_mismatch("valid cycles", 1, hit_count);
			if (first_hit != lat + 4)
				report_mismatch("valid delay", lat + 4, first_hit);
		end
		close_test();

		// Random enables on both phases
		// The valid count follows phase 0 only
		open_test("random_enable_stream");
		repeat (40) next_drive();
		lat = lat_count_t'($urandom % `RDP_MAX_READ_LATENCY);
		seq_read_latency_counter = lat;
		repeat (2) next_drive();
		en_count  = 0;
		hit_count = 0;
		for (k = 0; k < 200 + lat + 8; k++)
		begin
			if (k < 200)
			begin
				afi_rdata_en      = afi_phase_t'($urandom);
				afi_rdata_en_full = afi_phase_t'($urandom);
				en_count += afi_rdata_en[0];
			end
			else
			begin
				afi_rdata_en      = '0;
				afi_rdata_en_full = '0;
			end
			@(negedge pll_afi_clk);
			if (afi_rdata_valid == 2'b11)
				hit_count++;
			next_drive();
		end
		if (hit_count != en_count)
			report_mismatch("valid cycles", en_count, hit_count);
		close_test();

		// The compare process checks both reordered words every cycle
		open_test("data_reordering");
		repeat (100)
		begin
			ddio_phy_dq = $urandom;
			next_drive();
		end
		ddio_phy_dq = '0;
		close_test();

		// Isolated pulses open a six cycle window three edges later
		open_test("oct_window");
		repeat (3)
		begin
			afi_rdata_en_full = 2'b01;
			next_drive();
			afi_rdata_en_full = 2'b00;
			hit_count = 0;
			first_hit = 0;
			for (k = 0; k < 14; k++)
			begin
				@(negedge pll_afi_clk);
				if (force_oct_off == 2'b00)
				begin
					if (hit_count == 0)
						first_hit = k;
					hit_count++;
				end
			end
			if (hit_count != 6)
				report_mismatch("oct low cycles", 6, hit_count);
			if (first_hit != 3)
				report_mismatch("oct low start", 3, first_hit);
			next_drive();
		end
		// Pulses closer than the window length merge their windows
		for (k = 0; k < 40; k++)
		begin
			afi_rdata_en_full = (k % 5 == 0 || k == 2) ? 2'b01 : 2'b00;
			next_drive();
		end
		// Phase 1 alone never opens the window
		afi_rdata_en_full = 2'b10;
		next_drive();
		afi_rdata_en_full = 2'b00;
		repeat (12) next_drive();
		close_test();

		assert_errors = u_read_datapath.u_read_datapath_checker.error_count;
		$display("Tests passed %0d failed %0d assertion failures %0d", tests_passed,
			tests_failed, assert_errors);
		if (tests_failed == 0 && assert_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Ends a run that stalls somewhere in the sequence
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, the test sequence did not complete", TIMEOUT_NS);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- read_datapath.f
+incdir+hw
hw/read_dp_pkg.sv
hw/rdata_en_delay.sv
hw/read_latency_select.sv
hw/oct_control.sv
hw/read_data_map.sv
hw/read_datapath.sv
test/read_datapath_checker.sv
test/read_datapath_tb.sv

//--- Bender.yml
package:
  name: read_datapath

sources:
  - include_dirs:
      - hw
    files:
      - hw/read_dp_pkg.sv
      - hw/rdata_en_delay.sv
      - hw/read_latency_select.sv
      - hw/oct_control.sv
      - hw/read_data_map.sv
      - hw/read_datapath.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/read_datapath_checker.sv
      - test/read_datapath_tb.sv
